// ==== rtl/perf_pkg.sv ====
/*
  Shared widths, register map and probe types for the memory performance monitor.
  Counters are 44 bits wide and are read as two 32-bit words. The HI word
  carries only the upper 12 bits and is zero above them.
  Lane count is fixed at 4, so a per-cycle lane count fits in 3 bits.
*/
package perf_pkg;

    localparam int NUM_DCACHE_LANES   = 4;
    localparam int PERF_CTR_BITS      = 44;
    localparam int PERF_CTR_LANE_BITS = 3;
    localparam int CSR_ADDR_BITS      = 5;
    localparam int CSR_DATA_BITS      = 32;
    localparam int REPORT_PERIOD_BITS = 32;

    localparam logic [REPORT_PERIOD_BITS-1:0] DEFAULT_REPORT_PERIOD = 32'd10000;
    localparam logic                          DEFAULT_ENABLE        = 1'b1;

    // control word bits
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_CTRL          = 5'd0;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_PERIOD        = 5'd1;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_IFETCH_LO     = 5'd16;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_IFETCH_HI     = 5'd17;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_LOADS_LO      = 5'd18;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_LOADS_HI      = 5'd19;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_STORES_LO     = 5'd20;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_STORES_HI     = 5'd21;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_IFETCH_LAT_LO = 5'd22;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_IFETCH_LAT_HI = 5'd23;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_LOAD_LAT_LO   = 5'd24;
    localparam logic [CSR_ADDR_BITS-1:0] PERF_ADDR_LOAD_LAT_HI   = 5'd25;

    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } icache_probe_t;

    // one bit per lane, req_rw high for a store
    typedef struct packed {
        logic [NUM_DCACHE_LANES-1:0] req_valid;
        logic [NUM_DCACHE_LANES-1:0] req_ready;
        logic [NUM_DCACHE_LANES-1:0] req_rw;
        logic [NUM_DCACHE_LANES-1:0] rsp_valid;
        logic [NUM_DCACHE_LANES-1:0] rsp_ready;
    } dcache_probe_t;

    typedef struct packed {
        logic                     valid;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [CSR_DATA_BITS-1:0] data;
    } csr_write_t;

    typedef struct packed {
        logic enable;
        logic clear;
    } perf_ctrl_t;

    typedef struct packed {
        perf_ctr_t ifetches;
        perf_ctr_t loads;
        perf_ctr_t stores;
        perf_ctr_t ifetch_latency;
        perf_ctr_t load_latency;
    } perf_counters_t;

endpackage

// ==== rtl/perf_csr_block.sv ====
/*
  Control and read-back registers of the performance monitor.
  Writes take effect at the edge where csr_wr.valid is high. A 1 in CTRL bit 1
  gives a one-cycle clear in the following cycle. Reads have one cycle of
  latency and can be issued back to back. Unmapped addresses read as 0.
*/
`timescale 1ns/10ps

module perf_csr_block (
    input  logic                                  clk,
    input  logic                                  reset,
    input  perf_pkg::csr_write_t                  csr_wr,
    input  logic [perf_pkg::CSR_ADDR_BITS-1:0]    csr_rd_addr,
    input  perf_pkg::perf_counters_t              counters,
    output perf_pkg::perf_ctrl_t                  ctrl,
    output logic [perf_pkg::REPORT_PERIOD_BITS-1:0] report_period,
    output logic [perf_pkg::CSR_DATA_BITS-1:0]    csr_rd_data
);

    import perf_pkg::*;

    logic                          enable_r;
    logic                          clear_r;
    logic [REPORT_PERIOD_BITS-1:0] period_r;
    logic [CSR_DATA_BITS-1:0]      rd_word;
    logic                          wr_ctrl;
    logic                          wr_period;

    // upper counter bits, zero filled
    function automatic logic [CSR_DATA_BITS-1:0] hi_word(input perf_ctr_t value);
        return CSR_DATA_BITS'(value[PERF_CTR_BITS-1:CSR_DATA_BITS]);
    endfunction

    assign wr_ctrl   = csr_wr.valid && (csr_wr.addr == PERF_ADDR_CTRL);
    assign wr_period = csr_wr.valid && (csr_wr.addr == PERF_ADDR_PERIOD);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_r <= DEFAULT_ENABLE;
            clear_r  <= 1'b0;
            period_r <= DEFAULT_REPORT_PERIOD;
        end else begin
            // clear is a pulse, so it drops unless written again
            clear_r <= wr_ctrl && csr_wr.data[CTRL_CLEAR_BIT];
            if (wr_ctrl) begin
                enable_r <= csr_wr.data[CTRL_ENABLE_BIT];
            end
            if (wr_period) begin
                period_r <= csr_wr.data;
            end
        end
    end

    // read decode
    always_comb begin
        rd_word = '0;
        case (csr_rd_addr)
            PERF_ADDR_CTRL:          rd_word[CTRL_ENABLE_BIT] = enable_r;
            PERF_ADDR_PERIOD:        rd_word = period_r;
            PERF_ADDR_IFETCH_LO:     rd_word = counters.ifetches[CSR_DATA_BITS-1:0];
            PERF_ADDR_IFETCH_HI:     rd_word = hi_word(counters.ifetches);
            PERF_ADDR_LOADS_LO:      rd_word = counters.loads[CSR_DATA_BITS-1:0];
            PERF_ADDR_LOADS_HI:      rd_word = hi_word(counters.loads);
            PERF_ADDR_STORES_LO:     rd_word = counters.stores[CSR_DATA_BITS-1:0];
            PERF_ADDR_STORES_HI:     rd_word = hi_word(counters.stores);
            PERF_ADDR_IFETCH_LAT_LO: rd_word = counters.ifetch_latency[CSR_DATA_BITS-1:0];
            PERF_ADDR_IFETCH_LAT_HI: rd_word = hi_word(counters.ifetch_latency);
            PERF_ADDR_LOAD_LAT_LO:   rd_word = counters.load_latency[CSR_DATA_BITS-1:0];
            PERF_ADDR_LOAD_LAT_HI:   rd_word = hi_word(counters.load_latency);
            default:                 rd_word = '0;
        endcase
    end

    // registered read port, value held just before the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            csr_rd_data <= '0;
        end else begin
            csr_rd_data <= rd_word;
        end
    end

    assign ctrl.enable   = enable_r;
    assign ctrl.clear    = clear_r;
    assign report_period = period_r;

endmodule

// ==== rtl/ifetch_monitor.sv ====
/*
  Instruction fetch monitor. Observes the icache handshake only.
  A fire is valid and ready in the same cycle. The pending count is signed and
  keeps tracking while counting is disabled. Clear zeroes the counters but not
  the pending count.
*/
`timescale 1ns/10ps

module ifetch_monitor (
    input  logic                    clk,
    input  logic                    reset,
    input  perf_pkg::icache_probe_t icache,
    input  perf_pkg::perf_ctrl_t    ctrl,
    output perf_pkg::perf_ctr_t     ifetches,
    output perf_pkg::perf_ctr_t     ifetch_latency
);

    import perf_pkg::*;

    logic                            req_fire;
    logic                            rsp_fire;
    logic signed [PERF_CTR_BITS-1:0] pending;

    assign req_fire = icache.req_valid && icache.req_ready;
    assign rsp_fire = icache.rsp_valid && icache.rsp_ready;

    // outstanding fetches
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (req_fire && !rsp_fire) begin
            pending <= pending + 1;
        end else if (!req_fire && rsp_fire) begin
            pending <= pending - 1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.clear) begin
            ifetches       <= '0;
            ifetch_latency <= '0;
        end else if (ctrl.enable) begin
            ifetches       <= ifetches + PERF_CTR_BITS'(req_fire);
            // old pending value, one per cycle a fetch is in flight
            ifetch_latency <= ifetch_latency + $unsigned(pending);
        end
    end

endmodule

// ==== rtl/dcache_monitor.sv ====
/*
  Data cache monitor over NUM_DCACHE_LANES request lanes.
  Request fires are registered one cycle before they are counted, so a load
  seen at edge k lands in the loads counter at edge k+1. Responses are counted
  unbuffered. Every response is taken to answer a load.
  Pending loads keep tracking while disabled and survive a clear.
*/
`timescale 1ns/10ps

module dcache_monitor (
    input  logic                    clk,
    input  logic                    reset,
    input  perf_pkg::dcache_probe_t dcache,
    input  perf_pkg::perf_ctrl_t    ctrl,
    output perf_pkg::perf_ctr_t     loads,
    output perf_pkg::perf_ctr_t     stores,
    output perf_pkg::perf_ctr_t     load_latency
);

    import perf_pkg::*;

    logic [NUM_DCACHE_LANES-1:0]     req_fire;
    logic [NUM_DCACHE_LANES-1:0]     rd_fire;
    logic [NUM_DCACHE_LANES-1:0]     wr_fire;
    logic [NUM_DCACHE_LANES-1:0]     rsp_fire;
    logic [NUM_DCACHE_LANES-1:0]     rd_fire_r;
    logic [NUM_DCACHE_LANES-1:0]     wr_fire_r;
    logic [PERF_CTR_LANE_BITS-1:0]   rd_count;
    logic [PERF_CTR_LANE_BITS-1:0]   wr_count;
    logic [PERF_CTR_LANE_BITS-1:0]   rsp_count;
    logic signed [PERF_CTR_LANE_BITS:0] pending_delta;
    logic signed [PERF_CTR_BITS-1:0] pending;

    function automatic logic [PERF_CTR_LANE_BITS-1:0] popcount(
        input logic [NUM_DCACHE_LANES-1:0] bits
    );
        logic [PERF_CTR_LANE_BITS-1:0] n;
        n = '0;
        for (int i = 0; i < NUM_DCACHE_LANES; i++) begin
            n = n + PERF_CTR_LANE_BITS'(bits[i]);
        end
        return n;
    endfunction

    // per-lane fire split by direction
    assign req_fire = dcache.req_valid & dcache.req_ready;
    assign rd_fire  = req_fire & ~dcache.req_rw;
    assign wr_fire  = req_fire & dcache.req_rw;
    assign rsp_fire = dcache.rsp_valid & dcache.rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_fire_r <= '0;
            wr_fire_r <= '0;
        end else begin
            rd_fire_r <= rd_fire;
            wr_fire_r <= wr_fire;
        end
    end

    assign rd_count  = popcount(rd_fire_r);
    assign wr_count  = popcount(wr_fire_r);
    assign rsp_count = popcount(rsp_fire);

    // net change in outstanding loads, may go negative
    assign pending_delta = $signed({1'b0, rd_count}) - $signed({1'b0, rsp_count});

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + PERF_CTR_BITS'(pending_delta);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.clear) begin
            loads        <= '0;
            stores       <= '0;
            load_latency <= '0;
        end else if (ctrl.enable) begin
            loads        <= loads + PERF_CTR_BITS'(rd_count);
            stores       <= stores + PERF_CTR_BITS'(wr_count);
            load_latency <= load_latency + $unsigned(pending);
        end
    end

endmodule

// ==== rtl/report_timer.sv ====
/*
  Report pulse generator.
  The period counter starts at 0 and wraps once it reaches report_period, so
  ticks come every report_period+1 cycles, the first one right after reset.
  A falling edge of busy also ticks, in the first cycle busy is low.
  A period change takes effect against the running count.
*/
`timescale 1ns/10ps

module report_timer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    busy,
    input  logic [perf_pkg::REPORT_PERIOD_BITS-1:0] report_period,
    output logic                                    report_tick
);

    import perf_pkg::*;

    logic [REPORT_PERIOD_BITS-1:0] period_count;
    logic                          busy_prev;
    logic                          busy_fall;
    logic                          wrap;

    always_ff @(posedge clk) begin
        if (reset) begin
            period_count <= '0;
            busy_prev    <= 1'b0;
        end else begin
            busy_prev <= busy;
            if (period_count >= report_period) begin
                period_count <= '0;
            end else begin
                period_count <= period_count + 1'b1;
            end
        end
    end

    assign wrap      = (period_count == '0);
    assign busy_fall = busy_prev && !busy;

    // held low while in reset
    assign report_tick = !reset && (wrap || busy_fall);

endmodule

// ==== rtl/core_mem_perf.sv ====
/*
  Memory traffic performance monitor for one shader core.
  Observes the icache and dcache handshakes and never drives ready.
  Counters are read through a one-cycle registered read port.
  report_tick pulses on each period wrap and on the falling edge of busy.
*/
`timescale 1ns/10ps

module core_mem_perf (
    input  logic                               clk,
    input  logic                               reset,
    input  perf_pkg::icache_probe_t            icache,
    input  perf_pkg::dcache_probe_t            dcache,
    input  logic                               busy,
    input  perf_pkg::csr_write_t               csr_wr,
    input  logic [perf_pkg::CSR_ADDR_BITS-1:0] csr_rd_addr,
    output logic [perf_pkg::CSR_DATA_BITS-1:0] csr_rd_data,
    output logic                               report_tick
);

    import perf_pkg::*;

    perf_ctrl_t                    ctrl;
    logic [REPORT_PERIOD_BITS-1:0] report_period;
    perf_counters_t                counters;

    perf_csr_block csr_block (
        .clk           (clk),
        .reset         (reset),
        .csr_wr        (csr_wr),
        .csr_rd_addr   (csr_rd_addr),
        .counters      (counters),
        .ctrl          (ctrl),
        .report_period (report_period),
        .csr_rd_data   (csr_rd_data)
    );

    ifetch_monitor ifetch_mon (
        .clk            (clk),
        .reset          (reset),
        .icache         (icache),
        .ctrl           (ctrl),
        .ifetches       (counters.ifetches),
        .ifetch_latency (counters.ifetch_latency)
    );

    dcache_monitor dcache_mon (
        .clk          (clk),
        .reset        (reset),
        .dcache       (dcache),
        .ctrl         (ctrl),
        .loads        (counters.loads),
        .stores       (counters.stores),
        .load_latency (counters.load_latency)
    );

    report_timer timer (
        .clk           (clk),
        .reset         (reset),
        .busy          (busy),
        .report_period (report_period),
        .report_tick   (report_tick)
    );

endmodule

// ==== test/tb_core_mem_perf.sv ====
/*
  Directed testbench for core_mem_perf.
  A reference model of the counters and pending totals is updated once per
  rising edge from the inputs that the DUT sampled at that edge.
  Inputs change 1 ns after the rising edge. report_tick is sampled at the
  falling edge and read data just after the rising edge.
  Generated traffic never answers a request in the cycle it fires.
*/
`timescale 1ns/10ps

module tb_core_mem_perf;

    import perf_pkg::*;

    localparam int          CLK_HALF   = 4;
    // all five tests take well under 4000 cycles
    localparam int          MAX_CYCLES = 20000;
    localparam logic [31:0] SEED       = 32'ha16e_5e3a;

    logic                     clk;
    logic                     reset;
    icache_probe_t            icache;
    dcache_probe_t            dcache;
    logic                     busy;
    csr_write_t               csr_wr;
    logic [CSR_ADDR_BITS-1:0] csr_rd_addr;
    logic [CSR_DATA_BITS-1:0] csr_rd_data;
    logic                     report_tick;

    // reference model state
    logic                          enable_m;
    logic                          clear_m;
    logic [REPORT_PERIOD_BITS-1:0] period_m;
    longint                        if_pending;
    longint                        ld_pending;
    logic [NUM_DCACHE_LANES-1:0]   rd_buf_m;
    logic [NUM_DCACHE_LANES-1:0]   wr_buf_m;
    perf_counters_t                model;

    // requests fired in earlier cycles and not yet answered
    int   if_owed;
    int   ld_owed;
    int   err_count   = 0;
    int   check_count = 0;
    int   test_count  = 0;
    int   cycles      = 0;
    int   seed_val;
    logic tick_seen;

    core_mem_perf uut (
        .clk         (clk),
        .reset       (reset),
        .icache      (icache),
        .dcache      (dcache),
        .busy        (busy),
        .csr_wr      (csr_wr),
        .csr_rd_addr (csr_rd_addr),
        .csr_rd_data (csr_rd_data),
        .report_tick (report_tick)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic int lanes_set(input logic [NUM_DCACHE_LANES-1:0] bits);
        int n;
        n = 0;
        for (int i = 0; i < NUM_DCACHE_LANES; i++) begin
            n = n + int'(bits[i]);
        end
        return n;
    endfunction

    // register map view of the model
    function automatic logic [CSR_DATA_BITS-1:0] expected_word(
        input logic [CSR_ADDR_BITS-1:0] addr
    );
        perf_ctr_t v;
        v = '0;
        case (addr)
            PERF_ADDR_CTRL:   return {31'd0, enable_m};
            PERF_ADDR_PERIOD: return period_m;
            PERF_ADDR_IFETCH_LO, PERF_ADDR_IFETCH_HI:         v = model.ifetches;
            PERF_ADDR_LOADS_LO, PERF_ADDR_LOADS_HI:           v = model.loads;
            PERF_ADDR_STORES_LO, PERF_ADDR_STORES_HI:         v = model.stores;
            PERF_ADDR_IFETCH_LAT_LO, PERF_ADDR_IFETCH_LAT_HI: v = model.ifetch_latency;
            PERF_ADDR_LOAD_LAT_LO, PERF_ADDR_LOAD_LAT_HI:     v = model.load_latency;
            default:          return '0;
        endcase
        // odd addresses carry the upper bits
        if (addr[0]) begin
            return CSR_DATA_BITS'(v[PERF_CTR_BITS-1:CSR_DATA_BITS]);
        end
        return v[CSR_DATA_BITS-1:0];
    endfunction

    task automatic update_model();
        logic                        if_req;
        logic                        if_rsp;
        logic [NUM_DCACHE_LANES-1:0] rd_now;
        logic [NUM_DCACHE_LANES-1:0] wr_now;
        logic [NUM_DCACHE_LANES-1:0] rsp_now;
        logic                        wr_ctrl;
        if_req  = icache.req_valid && icache.req_ready;
        if_rsp  = icache.rsp_valid && icache.rsp_ready;
        rd_now  = dcache.req_valid & dcache.req_ready & ~dcache.req_rw;
        wr_now  = dcache.req_valid & dcache.req_ready & dcache.req_rw;
        rsp_now = dcache.rsp_valid & dcache.rsp_ready;
        wr_ctrl = csr_wr.valid && (csr_wr.addr == PERF_ADDR_CTRL);
        if (reset) begin
            enable_m   = 1'b1;
            clear_m    = 1'b0;
            period_m   = DEFAULT_REPORT_PERIOD;
            if_pending = 0;
            ld_pending = 0;
            rd_buf_m   = '0;
            wr_buf_m   = '0;
            model      = '0;
        end else begin
            if (clear_m) begin
                model = '0;
            end else if (enable_m) begin
                model.ifetches       = model.ifetches + perf_ctr_t'(if_req);
                model.ifetch_latency = model.ifetch_latency + perf_ctr_t'(if_pending);
                model.loads          = model.loads + perf_ctr_t'(lanes_set(rd_buf_m));
                model.stores         = model.stores + perf_ctr_t'(lanes_set(wr_buf_m));
                model.load_latency   = model.load_latency + perf_ctr_t'(ld_pending);
            end
            if_pending = if_pending + int'(if_req) - int'(if_rsp);
            ld_pending = ld_pending + lanes_set(rd_buf_m) - lanes_set(rsp_now);
            rd_buf_m   = rd_now;
            wr_buf_m   = wr_now;
            clear_m    = wr_ctrl && csr_wr.data[1];
            if (wr_ctrl) begin
                enable_m = csr_wr.data[0];
            end
            if (csr_wr.valid && (csr_wr.addr == PERF_ADDR_PERIOD)) begin
                period_m = csr_wr.data;
            end
        end
    endtask

    // one clock cycle with the inputs as they stand
    task automatic run_cycle();
        @(negedge clk);
        tick_seen = report_tick;
        @(posedge clk);
        update_model();
        #1;
    endtask

    task automatic set_idle();
        icache      = '0;
        dcache      = '0;
        csr_wr      = '0;
        csr_rd_addr = PERF_ADDR_CTRL;
    endtask

    task automatic check_word(input string name, input logic [CSR_DATA_BITS-1:0] got,
                              input logic [CSR_DATA_BITS-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ctr(input string name, input perf_ctr_t got, input perf_ctr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_tick(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic csr_write(input logic [CSR_ADDR_BITS-1:0] addr,
                             input logic [CSR_DATA_BITS-1:0] data);
        csr_wr.valid = 1'b1;
        csr_wr.addr  = addr;
        csr_wr.data  = data;
        run_cycle();
        csr_wr = '0;
    endtask

    // expected value is the model state held just before the sampling edge
    task automatic read_word(input logic [CSR_ADDR_BITS-1:0] addr,
                             output logic [CSR_DATA_BITS-1:0] got,
                             output logic [CSR_DATA_BITS-1:0] exp);
        csr_rd_addr = addr;
        exp = expected_word(addr);
        run_cycle();
        got = csr_rd_data;
    endtask

    task automatic read_counter(input string name, input logic [CSR_ADDR_BITS-1:0] lo_addr);
        logic [CSR_DATA_BITS-1:0] lo_got;
        logic [CSR_DATA_BITS-1:0] lo_exp;
        logic [CSR_DATA_BITS-1:0] hi_got;
        logic [CSR_DATA_BITS-1:0] hi_exp;
        read_word(lo_addr, lo_got, lo_exp);
        read_word(lo_addr + 1'b1, hi_got, hi_exp);
        check_word($sformatf("%s hi word", name), hi_got, hi_exp);
        check_ctr(name, {hi_got[PERF_CTR_BITS-CSR_DATA_BITS-1:0], lo_got},
                  {hi_exp[PERF_CTR_BITS-CSR_DATA_BITS-1:0], lo_exp});
    endtask

    task automatic check_counters();
        read_counter("ifetches", PERF_ADDR_IFETCH_LO);
        read_counter("loads", PERF_ADDR_LOADS_LO);
        read_counter("stores", PERF_ADDR_STORES_LO);
        read_counter("ifetch_latency", PERF_ADDR_IFETCH_LAT_LO);
        read_counter("load_latency", PERF_ADDR_LOAD_LAT_LO);
    endtask

    // random icache and dcache traffic, answers only for older requests
    task automatic mem_traffic(input int n, input bit request, input bit answer);
        int avail;
        for (int c = 0; c < n; c++) begin
            icache.rsp_ready = ($urandom % 4) != 0;
            icache.rsp_valid = answer && (if_owed > 0) && (($urandom % 2) == 1);
            if (icache.rsp_valid && icache.rsp_ready) begin
                if_owed--;
            end
            icache.req_valid = request && (($urandom % 2) == 1);
            icache.req_ready = ($urandom % 2) == 1;
            avail = answer ? ld_owed : 0;
            for (int i = 0; i < NUM_DCACHE_LANES; i++) begin
                dcache.rsp_ready[i] = ($urandom % 4) != 0;
                dcache.rsp_valid[i] = (avail > 0) && (($urandom % 2) == 1);
                if (dcache.rsp_valid[i] && dcache.rsp_ready[i]) begin
                    avail--;
                end
            end
            if (answer) begin
                ld_owed = avail;
            end
            dcache.req_valid = request ? NUM_DCACHE_LANES'($urandom) : '0;
            dcache.req_ready = NUM_DCACHE_LANES'($urandom);
            dcache.req_rw    = NUM_DCACHE_LANES'($urandom);
            run_cycle();
            if (icache.req_valid && icache.req_ready) begin
                if_owed++;
            end
            ld_owed += lanes_set(dcache.req_valid & dcache.req_ready & ~dcache.req_rw);
        end
    endtask

    task automatic drain();
        while (if_owed > 0 || ld_owed > 0) begin
            mem_traffic(1, 1'b0, 1'b1);
        end
        set_idle();
        run_cycle();
        run_cycle();
    endtask

    task automatic end_test(input string name, input int start);
        test_count++;
        if (err_count == start) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            $display("test %0d %s: fail, %0d mismatches", test_count, name, err_count - start);
        end
    endtask

    task automatic test_reset_defaults();
        int                       start;
        logic [CSR_DATA_BITS-1:0] got;
        logic [CSR_DATA_BITS-1:0] exp;
        start = err_count;
        repeat (2) begin
            run_cycle();
            check_tick("report_tick in reset", tick_seen, 1'b0);
            check_word("csr_rd_data in reset", csr_rd_data, '0);
        end
        reset = 1'b0;
        read_word(PERF_ADDR_CTRL, got, exp);
        check_word("ctrl", got, 32'd1);
        read_word(PERF_ADDR_PERIOD, got, exp);
        check_word("period", got, 32'd10000);
        check_counters();
        end_test("reset defaults", start);
    endtask

    task automatic test_fetch_counting();
        int start;
        int fires;
        int cyc;
        int last_due;
        int delay;
        int due[$];
        int dropped;
        start    = err_count;
        fires    = 0;
        cyc      = 0;
        last_due = 0;
        set_idle();
        while (fires < 40 || due.size() > 0) begin
            icache.rsp_valid = (due.size() > 0) && (due[0] <= cyc);
            icache.rsp_ready = 1'b1;
            icache.req_valid = (fires < 40) && (($urandom % 3) != 0);
            icache.req_ready = ($urandom % 4) != 0;
            if (icache.rsp_valid) begin
                dropped = due.pop_front();
            end
            if (icache.req_valid && icache.req_ready) begin
                fires++;
                delay = 1 + int'($urandom % 6);
                // one response per cycle, so due times stay in order
                last_due = (cyc + delay > last_due) ? cyc + delay : last_due + 1;
                due.push_back(last_due);
            end
            run_cycle();
            cyc++;
        end
        set_idle();
        run_cycle();
        check_counters();
        end_test("fetch counting", start);
    endtask

    task automatic test_load_store_counting();
        int start;
        start = err_count;
        set_idle();
        mem_traffic(200, 1'b1, 1'b1);
        drain();
        check_counters();
        end_test("load and store counting", start);
    endtask

    task automatic test_enable_clear();
        int start;
        start = err_count;
        set_idle();
        csr_write(PERF_ADDR_CTRL, 32'h0);
        // leave requests outstanding so pending totals carry over
        mem_traffic(30, 1'b1, 1'b0);
        set_idle();
        run_cycle();
        run_cycle();
        check_counters();
        csr_write(PERF_ADDR_CTRL, 32'h2);
        run_cycle();
        check_counters();
        csr_write(PERF_ADDR_CTRL, 32'h1);
        drain();
        check_counters();
        end_test("enable and clear", start);
    endtask

    task automatic test_report_pulse();
        int   start;
        logic found;
        start = err_count;
        found = 1'b0;
        set_idle();
        busy = 1'b0;
        csr_write(PERF_ADDR_PERIOD, 32'd5);
        for (int i = 0; i < 20 && !found; i++) begin
            run_cycle();
            found = tick_seen;
        end
        if (!found) begin
            err_count++;
            $display("no report tick came within 20 cycles after the period was set to 5");
        end else begin
            for (int i = 1; i <= 6; i++) begin
                run_cycle();
                check_tick($sformatf("report_tick %0d cycles after wrap", i), tick_seen,
                           i == 6);
            end
        end
        busy = 1'b1;
        repeat (3) run_cycle();
        busy = 1'b0;
        run_cycle();
        check_tick("report_tick on busy fall", tick_seen, 1'b1);
        end_test("report pulse", start);
    endtask

    initial begin
        seed_val = $urandom(SEED);
        reset    = 1'b1;
        busy     = 1'b0;
        if_owed  = 0;
        ld_owed  = 0;
        set_idle();
        @(posedge clk);
        update_model();
        #1;
        test_reset_defaults();
        test_fetch_counting();
        test_load_store_counting();
        test_enable_clear();
        test_report_pulse();
        $display("tests: %0d, checks: %0d, failures: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/perf_pkg.sv
rtl/perf_csr_block.sv
rtl/ifetch_monitor.sv
rtl/dcache_monitor.sv
rtl/report_timer.sv
rtl/core_mem_perf.sv
test/tb_core_mem_perf.sv
